// File: verilog.f
hw/csrPkg.sv
hw/csrAccess.sv
hw/csrInterrupt.sv
hw/csrTrapSetup.sv
hw/intArbiter.sv
hw/csrIntTop.sv
verification/tbClock.sv
verification/csrIntTb.sv

// File: Makefile
# Verilator lint and simulation of the interrupt CSR subsystem

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= csrIntTb
RTL_TOP   ?= csrIntTop
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= RESULT: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Output is captured in a shell variable, status comes from the search
sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/csrIntTb.sv
// Directed tests at xlen 32 with S mode present; inputs change on falling edges, random data from a fixed seed
`timescale 1ns/1ps
`default_nettype none

module csrIntTb;

  localparam int xlen       = 32;
  localparam int ackTimeout = 20;   // Cycles allowed per handshake phase

  logic clk, reset;
  logic req;
  csrPkg::csrOpT op;
  logic [11:0] addr;
  logic [xlen-1:0] wdata;
  csrPkg::privT priv;
  logic ack, illegal;
  logic [xlen-1:0] rdata;
  logic extInt, timerInt, swInt;
  logic intValid, intToSuper;
  csrPkg::intCauseT intCause;

  int errorCount   = 0;
  int timeoutCount = 0;
  int checkCount   = 0;
  int riseCycles, fallCycles;   // Handshake latency of the last access

  // Reference model of the status, delegation and enable registers
  logic modMie, modSie;
  logic [11:0] modDeleg, modIe;

  tbClock #(.periodNs(10), .resetCycles(2)) tbClock_inst (.clk(clk), .reset(reset));

  csrIntTop #(.xlen(xlen), .sSupported(1)) csrIntTop_inst (
    .clk(clk), .reset(reset), .req(req), .op(op), .addr(addr), .wdata(wdata), .priv(priv),
    .ack(ack), .rdata(rdata), .illegal(illegal),
    .extInt(extInt), .timerInt(timerInt), .swInt(swInt),
    .intValid(intValid), .intCause(intCause), .intToSuper(intToSuper)
  );

  ////////////////////
  // Helpers
  ////////////////////
  task automatic checkEq(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                         input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic setPriv(input csrPkg::privT p);
    @(negedge clk);
    priv = p;   // Only changed between requests
  endtask

  // Full four-phase request that leaves its latencies in riseCycles and fallCycles
  task automatic doAccess(input csrPkg::csrOpT o, input logic [11:0] a,
                          input logic [xlen-1:0] d, output logic [xlen-1:0] rd,
                          output logic ill);
    @(negedge clk);
    req = 1'b1;
    op = o;
    addr = a;
    wdata = d;
    riseCycles = 0;
    while (!ack && riseCycles < ackTimeout) begin
      @(negedge clk);
      riseCycles++;
    end
    if (!ack) begin
      timeoutCount++;
      $display("Timeout: ack never rose for CSR %0h", a);
    end
    rd = rdata;
    ill = illegal;
    req = 1'b0;
    fallCycles = 0;
    while (ack && fallCycles < ackTimeout) begin
      @(negedge clk);
      fallCycles++;
    end
    if (ack) begin
      timeoutCount++;
      $display("Timeout: ack stayed high after req dropped for CSR %0h", a);
    end
  endtask

  function automatic logic [xlen-1:0] applyOp(input csrPkg::csrOpT o,
                                              input logic [xlen-1:0] old, d);
    case (o)
      csrPkg::opWrite: applyOp = d;
      csrPkg::opSet:   applyOp = old | d;
      csrPkg::opClear: applyOp = old & ~d;
      default:         applyOp = old;
    endcase
  endfunction

  // Register images as the model sees them
  function automatic logic [xlen-1:0] modelRead(input logic [11:0] a);
    case (a)
      csrPkg::csrAddrMstatus: modelRead = {28'b0, modMie, 1'b0, modSie, 1'b0};
      csrPkg::csrAddrSstatus: modelRead = {30'b0, modSie, 1'b0};
      csrPkg::csrAddrMideleg: modelRead = {20'b0, modDeleg};
      csrPkg::csrAddrMie:     modelRead = {20'b0, modIe};
      csrPkg::csrAddrSie:     modelRead = {20'b0, modIe & modDeleg & 12'h222};
      default:                modelRead = '0;
    endcase
  endfunction

  task automatic modelUpdate(input csrPkg::csrOpT o, input logic [11:0] a,
                             input logic [xlen-1:0] d);
    logic [xlen-1:0] nv;
    nv = applyOp(o, modelRead(a), d);
    case (a)
      csrPkg::csrAddrMstatus: begin
        modMie = nv[3];
        modSie = nv[1];
      end
      csrPkg::csrAddrSstatus: modSie = nv[1];
      csrPkg::csrAddrMideleg: modDeleg = nv[11:0] & 12'h222;
      csrPkg::csrAddrMie:     modIe = nv[11:0] & 12'hAAA;
      csrPkg::csrAddrSie:     modIe = (modIe & 12'h888) | (nv[11:0] & 12'h222);   // M fields kept
      default: ;
    endcase
  endtask

  // Legal access to a modeled register that expects the old value back
  task automatic accessAndCheck(input csrPkg::csrOpT o, input logic [11:0] a,
                                input logic [xlen-1:0] d, input string what);
    logic [xlen-1:0] rd, expRd;
    logic ill;
    expRd = modelRead(a);
    doAccess(o, a, d, rd, ill);
    checkEq(32'(ill), 32'(1'b0), {what, " illegal"});
    checkEq(rd, expRd, {what, " rdata"});
    if (o != csrPkg::opRead) modelUpdate(o, a, d);
  endtask

  task automatic expectIllegal(input csrPkg::csrOpT o, input logic [11:0] a,
                               input logic [xlen-1:0] d, input string what);
    logic [xlen-1:0] rd;
    logic ill;
    doAccess(o, a, d, rd, ill);
    checkEq(32'(ill), 32'(1'b1), {what, " illegal"});
    checkEq(rd, '0, {what, " rdata"});
  endtask

  task automatic readExpect(input logic [11:0] a, input logic [xlen-1:0] exp, input string what);
    logic [xlen-1:0] rd;
    logic ill;
    doAccess(csrPkg::opRead, a, '0, rd, ill);
    checkEq(32'(ill), 32'(1'b0), {what, " illegal"});
    checkEq(rd, exp, what);
  endtask

  // M level before S level, order MEI MSI MTI SEI SSI STI within each
  // Cause code equals the bit index
  task automatic expectedPick(input logic [11:0] pend, en, deleg, input csrPkg::privT p,
                              input logic mie, sie, output logic valid,
                              output logic [3:0] cause, output logic toSuper);
    int order [6];
    logic mOk, sOk;
    order = '{11, 3, 7, 9, 1, 5};
    mOk = (p != csrPkg::privMachine) || mie;
    sOk = (p == csrPkg::privUser) || (p == csrPkg::privSuper && sie);
    valid = 1'b0;
    cause = 4'd0;
    toSuper = 1'b0;
    foreach (order[i]) begin
      if (!valid && mOk && pend[order[i]] && en[order[i]] && !deleg[order[i]]) begin
        valid = 1'b1;
        cause = 4'(order[i]);
      end
    end
    foreach (order[i]) begin
      if (!valid && sOk && pend[order[i]] && en[order[i]] && deleg[order[i]]) begin
        valid = 1'b1;
        cause = 4'(order[i]);
        toSuper = 1'b1;
      end
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic resetTest();
    logic [11:0] regs [7];
    regs = '{csrPkg::csrAddrMstatus, csrPkg::csrAddrSstatus, csrPkg::csrAddrMideleg,
             csrPkg::csrAddrMie, csrPkg::csrAddrMip, csrPkg::csrAddrSie, csrPkg::csrAddrSip};
    checkEq(32'(ack), 32'(1'b0), "ack after reset");
    checkEq(32'(intValid), 32'(1'b0), "intValid after reset");
    checkEq(32'(intToSuper), 32'(1'b0), "intToSuper after reset");
    foreach (regs[i]) begin
      readExpect(regs[i], '0, "register after reset");
      checkEq(32'(riseCycles), 32'd1, "req to ack cycles");
      checkEq(32'(fallCycles), 32'd1, "req drop to ack drop cycles");
    end
  endtask

  task automatic randomTest();
    logic [11:0] regs [5];
    logic [11:0] a;
    csrPkg::csrOpT o;
    regs = '{csrPkg::csrAddrMstatus, csrPkg::csrAddrSstatus, csrPkg::csrAddrMideleg,
             csrPkg::csrAddrMie, csrPkg::csrAddrSie};
    for (int i = 0; i < 40; i++) begin
      a = regs[$urandom % 5];
      o = csrPkg::csrOpT'($urandom % 4);
      accessAndCheck(o, a, $urandom, "random access");
    end
    foreach (regs[i]) accessAndCheck(csrPkg::opRead, regs[i], '0, "final readback");
  endtask

  task automatic privTest();
    setPriv(csrPkg::privSuper);
    expectIllegal(csrPkg::opWrite, csrPkg::csrAddrMie, $urandom, "mie from S");
    expectIllegal(csrPkg::opSet, csrPkg::csrAddrMstatus, 32'hA, "mstatus from S");
    accessAndCheck(csrPkg::opRead, csrPkg::csrAddrSie, '0, "sie from S");
    accessAndCheck(csrPkg::opSet, csrPkg::csrAddrSstatus, 32'h2, "sstatus from S");
    setPriv(csrPkg::privUser);
    expectIllegal(csrPkg::opClear, csrPkg::csrAddrSstatus, 32'h2, "sstatus from U");
    expectIllegal(csrPkg::opWrite, csrPkg::csrAddrSie, 32'hFFFF_FFFF, "sie from U");
    setPriv(csrPkg::privMachine);
    expectIllegal(csrPkg::opWrite, 12'h7C0, $urandom, "unknown CSR");
    // Nothing above may have changed state
    accessAndCheck(csrPkg::opRead, csrPkg::csrAddrMstatus, '0, "mstatus unchanged");
    accessAndCheck(csrPkg::opRead, csrPkg::csrAddrMie, '0, "mie unchanged");
    accessAndCheck(csrPkg::opRead, csrPkg::csrAddrSie, '0, "sie unchanged");
  endtask

  task automatic pendingTest();
    logic [xlen-1:0] rd;
    logic ill;
    setPriv(csrPkg::privMachine);
    accessAndCheck(csrPkg::opWrite, csrPkg::csrAddrMideleg, 32'h222, "delegate S ints");
    @(negedge clk) timerInt = 1'b1;   // One-cycle pulse
    @(negedge clk) timerInt = 1'b0;
    readExpect(csrPkg::csrAddrMip, 32'h0A0, "mip after timer pulse");
    readExpect(csrPkg::csrAddrSip, 32'h020, "sip after timer pulse");
    @(negedge clk) swInt = 1'b1;
    @(negedge clk) swInt = 1'b0;
    readExpect(csrPkg::csrAddrMip, 32'h0AA, "mip after sw pulse");
    readExpect(csrPkg::csrAddrSip, 32'h022, "sip after sw pulse");
    // SSIP clears while MTIP and STIP come back from the held timer
    @(negedge clk) timerInt = 1'b1;
    doAccess(csrPkg::opWrite, csrPkg::csrAddrMip, '0, rd, ill);
    checkEq(rd, 32'h0AA, "mip write old value");
    readExpect(csrPkg::csrAddrMip, 32'h0A0, "mip written with timer high");
    @(negedge clk) timerInt = 1'b0;
    doAccess(csrPkg::opWrite, csrPkg::csrAddrMip, '0, rd, ill);
    readExpect(csrPkg::csrAddrMip, 32'h000, "mip cleared with timer low");
    // MEIP tracks extInt while delegated SEIP stays sticky
    @(negedge clk) extInt = 1'b1;
    @(negedge clk);
    readExpect(csrPkg::csrAddrMip, 32'hA00, "mip with extInt high");
    @(negedge clk) extInt = 1'b0;
    readExpect(csrPkg::csrAddrMip, 32'h200, "mip with extInt low");
    readExpect(csrPkg::csrAddrSip, 32'h200, "sip with SEIP");
    doAccess(csrPkg::opWrite, csrPkg::csrAddrMip, '0, rd, ill);
  endtask

  task automatic arbTest();
    logic [11:0] enables [5];
    csrPkg::privT privs [3];
    logic [xlen-1:0] stVal;
    logic expValid, expToS;
    logic [3:0] expCause;
    int waitCycles;
    enables = '{12'hAAA, 12'h222, 12'h0A0, 12'h088, 12'h022};
    privs = '{csrPkg::privUser, csrPkg::privSuper, csrPkg::privMachine};
    setPriv(csrPkg::privMachine);
    @(negedge clk);
    extInt = 1'b1;
    timerInt = 1'b1;
    swInt = 1'b1;
    readExpect(csrPkg::csrAddrMip, 32'hAAA, "mip with all sources");
    foreach (enables[e]) begin
      for (int st = 0; st < 4; st++) begin
        stVal = '0;
        stVal[3] = st[1];   // MIE
        stVal[1] = st[0];   // SIE
        setPriv(csrPkg::privMachine);
        accessAndCheck(csrPkg::opWrite, csrPkg::csrAddrMie, 32'(enables[e]), "arb mie");
        accessAndCheck(csrPkg::opWrite, csrPkg::csrAddrMstatus, stVal, "arb mstatus");
        foreach (privs[p]) begin
          setPriv(privs[p]);
          expectedPick(12'hAAA, modIe, modDeleg, privs[p], modMie, modSie,
                       expValid, expCause, expToS);
          waitCycles = 0;
          while (waitCycles == 0 || ((intValid !== expValid || intToSuper !== expToS ||
                 (expValid && intCause !== expCause)) && waitCycles < 2)) begin
            @(negedge clk);
            waitCycles++;
          end
          checkEq(32'(intValid), 32'(expValid), "intValid");
          checkEq(32'(intToSuper), 32'(expToS), "intToSuper");
          if (expValid) checkEq(32'(intCause), 32'(expCause), "intCause");
        end
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int n;
    void'($urandom(32'h482f_a195));
    req = 1'b0;
    op = csrPkg::opRead;
    addr = '0;
    wdata = '0;
    priv = csrPkg::privMachine;
    extInt = 1'b0;
    timerInt = 1'b0;
    swInt = 1'b0;
    modMie = 1'b0;
    modSie = 1'b0;
    modDeleg = '0;
    modIe = '0;
    n = 0;
    @(negedge clk);
    while (reset && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (reset) begin
      timeoutCount++;
      $display("Timeout: reset was never released");
    end
    resetTest();
    randomTest();
    privTest();
    pendingTest();
    arbTest();
    $display("Checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
// Free-running clock with an active-high reset held for the first few cycles; period in ns
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int periodNs    = 10,
  parameter int resetCycles = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;   // 50% duty
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: hw/csrIntTop.sv
// Interrupt CSR subsystem top with a four-phase request port; trap entry and the rest of the CSR file live elsewhere
`timescale 1ns/1ps
`default_nettype none

module csrIntTop #(
  parameter int xlen       = 32,   // 32 or 64
  parameter int sSupported = 1     // S mode present
) (
  input  wire logic                             clk,
  input  wire logic                             reset,
  input  wire logic                             req,
  input  wire csrPkg::csrOpT                    op,
  input  wire logic [csrPkg::csrAddrWidth-1:0]  addr,
  input  wire logic [xlen-1:0]                  wdata,
  input  wire csrPkg::privT                     priv,
  output logic                                  ack,
  output logic [xlen-1:0]                       rdata,
  output logic                                  illegal,
  input  wire logic                             extInt,
  input  wire logic                             timerInt,
  input  wire logic                             swInt,
  output logic                                  intValid,
  output csrPkg::intCauseT                      intCause,
  output logic                                  intToSuper
);

  logic writeMstatus, writeSstatus, writeMideleg;
  logic writeMie, writeMip, writeSie, writeSip;
  logic [xlen-1:0] newValue;
  logic [csrPkg::intWidth-1:0] midelegReg, mipReg, mieReg, sipReg, sieReg;
  logic mstatusMie, mstatusSie;

  ////////////////////
  // Request side
  ////////////////////
  csrAccess #(.xlen(xlen), .sSupported(sSupported)) csrAccess_inst (
    .clk(clk), .reset(reset),
    .req(req), .op(op), .addr(addr), .wdata(wdata), .priv(priv),
    .ack(ack), .rdata(rdata), .illegal(illegal),
    .mstatusMie(mstatusMie), .mstatusSie(mstatusSie),
    .midelegReg(midelegReg), .mipReg(mipReg), .mieReg(mieReg),
    .sipReg(sipReg), .sieReg(sieReg),
    .writeMstatus(writeMstatus), .writeSstatus(writeSstatus),
    .writeMideleg(writeMideleg), .writeMie(writeMie), .writeMip(writeMip),
    .writeSie(writeSie), .writeSip(writeSip),
    .newValue(newValue)
  );

  ////////////////////
  // Register blocks
  ////////////////////
  csrInterrupt #(.xlen(xlen), .sSupported(sSupported)) csrInterrupt_inst (
    .clk(clk), .reset(reset),
    .extInt(extInt), .timerInt(timerInt), .swInt(swInt),
    .midelegReg(midelegReg),
    .writeMip(writeMip), .writeMie(writeMie), .writeSip(writeSip), .writeSie(writeSie),
    .newValue(newValue),
    .mipReg(mipReg), .mieReg(mieReg), .sipReg(sipReg), .sieReg(sieReg)
  );

  csrTrapSetup #(.xlen(xlen), .sSupported(sSupported)) csrTrapSetup_inst (
    .clk(clk), .reset(reset),
    .writeMstatus(writeMstatus), .writeSstatus(writeSstatus), .writeMideleg(writeMideleg),
    .newValue(newValue),
    .midelegReg(midelegReg), .mstatusMie(mstatusMie), .mstatusSie(mstatusSie)
  );

  // Registered pick, lags the registers by a cycle
  intArbiter intArbiter_inst (
    .clk(clk), .reset(reset), .priv(priv),
    .mipReg(mipReg), .mieReg(mieReg), .midelegReg(midelegReg),
    .mstatusMie(mstatusMie), .mstatusSie(mstatusSie),
    .intValid(intValid), .intCause(intCause), .intToSuper(intToSuper)
  );

endmodule

`default_nettype wire

// File: hw/intArbiter.sv
// Picks the interrupt the current privilege must take and registers it, so results lag inputs by one cycle
`timescale 1ns/1ps
`default_nettype none

module intArbiter (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire csrPkg::privT                  priv,
  input  wire logic [csrPkg::intWidth-1:0]   mipReg,
  input  wire logic [csrPkg::intWidth-1:0]   mieReg,
  input  wire logic [csrPkg::intWidth-1:0]   midelegReg,
  input  wire logic                          mstatusMie,
  input  wire logic                          mstatusSie,
  output logic                               intValid,
  output csrPkg::intCauseT                   intCause,
  output logic                               intToSuper
);

  logic [csrPkg::intWidth-1:0] pendEn;   // Pending and enabled
  logic [csrPkg::intWidth-1:0] mTake;    // Taken at machine level
  logic [csrPkg::intWidth-1:0] sTake;    // Taken at supervisor level
  logic [csrPkg::intWidth-1:0] pickVec;  // Level that wins
  logic mEnable, sEnable;
  csrPkg::intCauseT selCause;

  assign pendEn = mipReg & mieReg;

  // M level when below M or MIE set, S level from U or from S with SIE
  assign mEnable = (priv != csrPkg::privMachine) | mstatusMie;
  assign sEnable = (priv == csrPkg::privUser) |
                   ((priv == csrPkg::privSuper) & mstatusSie);

  assign mTake = pendEn & ~midelegReg & {csrPkg::intWidth{mEnable}};
  assign sTake = pendEn &  midelegReg & {csrPkg::intWidth{sEnable}};

  assign pickVec = (|mTake) ? mTake : sTake;   // Machine level first

  ////////////////////
  // Priority within a level
  ////////////////////
  always_comb begin
    if (pickVec[11])     selCause = csrPkg::causeMei;
    else if (pickVec[3]) selCause = csrPkg::causeMsi;
    else if (pickVec[7]) selCause = csrPkg::causeMti;
    else if (pickVec[9]) selCause = csrPkg::causeSei;
    else if (pickVec[1]) selCause = csrPkg::causeSsi;
    else if (pickVec[5]) selCause = csrPkg::causeSti;
    else                 selCause = csrPkg::causeMei;   // Don't care when nothing pending
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      intValid   <= 1'b0;
      intToSuper <= 1'b0;
    end else begin
      intValid   <= |(mTake | sTake);
      intToSuper <= ~(|mTake) & (|sTake);   // Only delegated ones go to S
    end
  end

  always_ff @(posedge clk) begin
    intCause <= selCause;
  end

endmodule

`default_nettype wire

// File: hw/csrTrapSetup.sv
// Holds mideleg and the mstatus MIE and SIE bits only; other mstatus fields read as zero
`timescale 1ns/1ps
`default_nettype none

module csrTrapSetup #(
  parameter int xlen       = 32,
  parameter int sSupported = 1
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          writeMstatus,
  input  wire logic                          writeSstatus,
  input  wire logic                          writeMideleg,
  input  wire logic [xlen-1:0]               newValue,
  output logic [csrPkg::intWidth-1:0]        midelegReg,
  output logic                               mstatusMie,
  output logic                               mstatusSie
);

  // Delegation needs S mode
  localparam logic [csrPkg::intWidth-1:0] delegMask =
    (sSupported != 0) ? csrPkg::midelegWriteMask : '0;
  localparam logic sieAllowed = (sSupported != 0);

  ////////////////////
  // mideleg
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      midelegReg <= '0;
    end else if (writeMideleg) begin
      midelegReg <= newValue[csrPkg::intWidth-1:0] & delegMask;
    end
  end

  ////////////////////
  // Global enables
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatusMie <= 1'b0;
    end else if (writeMstatus) begin
      mstatusMie <= newValue[3];   // MIE
    end
  end

  // SIE reachable through both mstatus and sstatus
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatusSie <= 1'b0;
    end else if (writeMstatus || writeSstatus) begin
      mstatusSie <= newValue[1] & sieAllowed;
    end
  end

endmodule

`default_nettype wire

// File: hw/csrInterrupt.sv
// Pending and enable registers for M and S interrupts; no user-mode interrupts, and S views read zero without S support
`timescale 1ns/1ps
`default_nettype none

module csrInterrupt #(
  parameter int xlen       = 32,
  parameter int sSupported = 1
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          extInt,
  input  wire logic                          timerInt,
  input  wire logic                          swInt,
  input  wire logic [csrPkg::intWidth-1:0]   midelegReg,
  input  wire logic                          writeMip,
  input  wire logic                          writeMie,
  input  wire logic                          writeSip,
  input  wire logic                          writeSie,
  input  wire logic [xlen-1:0]               newValue,
  output logic [csrPkg::intWidth-1:0]        mipReg,
  output logic [csrPkg::intWidth-1:0]        mieReg,
  output logic [csrPkg::intWidth-1:0]        sipReg,
  output logic [csrPkg::intWidth-1:0]        sieReg
);

  localparam int iw = csrPkg::intWidth;

  // Pending write masks collapse to zero without S mode
  localparam logic [iw-1:0] mipMask = (sSupported != 0) ? csrPkg::mipWriteMask : '0;
  localparam logic [iw-1:0] sipMask = (sSupported != 0) ? csrPkg::sipWriteMask : '0;
  localparam logic [iw-1:0] sField  = csrPkg::sieWriteMask;                        // S fields
  localparam logic [iw-1:0] mField  = csrPkg::mieWriteMask & ~csrPkg::sieWriteMask; // M fields

  logic [iw-1:0] intSrc;      // Source vector with delegation
  logic [9:0]    pendStored;  // Sticky pending bits below MEIP
  logic [iw-1:0] ipFull;      // Full pending image
  logic [iw-1:0] ieReg;       // Shared enable register
  logic [iw-1:0] wrVal;       // Low bits of the write data

  assign wrVal = newValue[iw-1:0];

  ////////////////////
  // Sources
  ////////////////////
  always_comb begin
    intSrc     = '0;
    intSrc[11] = extInt;                     // MEIP
    intSrc[9]  = extInt   & midelegReg[9];   // SEIP
    intSrc[7]  = timerInt;                   // MTIP
    intSrc[5]  = timerInt & midelegReg[5];   // STIP
    intSrc[3]  = swInt;                      // MSIP
    intSrc[1]  = swInt    & midelegReg[1];   // SSIP
  end

  // Pending bits, a write sets masked bits and reloads the rest from source
  always_ff @(posedge clk) begin
    if (reset) begin
      pendStored <= '0;
    end else if (writeMip) begin
      pendStored <= (wrVal[9:0] & mipMask[9:0]) | (intSrc[9:0] & ~mipMask[9:0]);
    end else if (writeSip) begin
      pendStored <= (wrVal[9:0] & sipMask[9:0]) | (intSrc[9:0] & ~sipMask[9:0]);
    end else begin
      pendStored <= pendStored | intSrc[9:0];   // Sticky
    end
  end

  // Enables, sie only touches the S fields
  always_ff @(posedge clk) begin
    if (reset) begin
      ieReg <= '0;
    end else if (writeMie) begin
      ieReg <= wrVal & csrPkg::mieWriteMask;
    end else if (writeSie && sSupported != 0) begin
      ieReg <= (wrVal & sField) | (ieReg & mField);
    end
  end

  ////////////////////
  // Views
  ////////////////////
  assign ipFull = {intSrc[11], 1'b0, pendStored};   // MEIP not stored

  assign mipReg = ipFull;
  assign mieReg = ieReg;

  // Only delegated S interrupts show in the S views
  assign sipReg = (sSupported != 0) ? (ipFull & midelegReg & sField) : '0;
  assign sieReg = (sSupported != 0) ? (ieReg & midelegReg & sField) : '0;

endmodule

`default_nettype wire

// File: hw/csrAccess.sv
// Four-phase CSR port that serves one access per req and returns the pre-access value; illegal accesses change nothing
`timescale 1ns/1ps
`default_nettype none

module csrAccess #(
  parameter int xlen       = 32,
  parameter int sSupported = 1
) (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               req,
  input  wire csrPkg::csrOpT                      op,
  input  wire logic [csrPkg::csrAddrWidth-1:0]    addr,
  input  wire logic [xlen-1:0]                    wdata,
  input  wire csrPkg::privT                       priv,
  output logic                                    ack,
  output logic [xlen-1:0]                         rdata,
  output logic                                    illegal,
  input  wire logic                               mstatusMie,
  input  wire logic                               mstatusSie,
  input  wire logic [csrPkg::intWidth-1:0]        midelegReg,
  input  wire logic [csrPkg::intWidth-1:0]        mipReg,
  input  wire logic [csrPkg::intWidth-1:0]        mieReg,
  input  wire logic [csrPkg::intWidth-1:0]        sipReg,
  input  wire logic [csrPkg::intWidth-1:0]        sieReg,
  output logic                                    writeMstatus,
  output logic                                    writeSstatus,
  output logic                                    writeMideleg,
  output logic                                    writeMie,
  output logic                                    writeMip,
  output logic                                    writeSie,
  output logic                                    writeSip,
  output logic [xlen-1:0]                         newValue
);

  csrPkg::accStateT state;
  logic hitMstatus, hitSstatus, hitMideleg, hitMie, hitMip, hitSie, hitSip;
  logic machReg, superReg;   // Register class of the decoded address
  logic accessOk;            // Known address and enough privilege
  logic start;               // First sampled req in idle
  logic doWrite;             // Legal modifying access this cycle
  logic [xlen-1:0] readValue;

  ////////////////////
  // Address decode
  ////////////////////
  assign hitMstatus = (addr == csrPkg::csrAddrMstatus);
  assign hitSstatus = (addr == csrPkg::csrAddrSstatus);
  assign hitMideleg = (addr == csrPkg::csrAddrMideleg);
  assign hitMie     = (addr == csrPkg::csrAddrMie);
  assign hitMip     = (addr == csrPkg::csrAddrMip);
  assign hitSie     = (addr == csrPkg::csrAddrSie);
  assign hitSip     = (addr == csrPkg::csrAddrSip);

  assign machReg  = hitMstatus | hitMideleg | hitMie | hitMip;
  assign superReg = hitSstatus | hitSie | hitSip;

  // Machine regs need M mode, S regs need S or M mode and S support
  assign accessOk = (machReg & (priv == csrPkg::privMachine)) |
                    (superReg & (priv != csrPkg::privUser) & (sSupported != 0));

  // Read mux builds the status images from the enable bits
  always_comb begin
    readValue = '0;
    if (hitMstatus) begin
      readValue[3] = mstatusMie;   // MIE
      readValue[1] = mstatusSie;   // SIE
    end else if (hitSstatus) begin
      readValue[1] = mstatusSie;   // Only SIE visible
    end else if (hitMideleg) begin
      readValue[csrPkg::intWidth-1:0] = midelegReg;
    end else if (hitMie) begin
      readValue[csrPkg::intWidth-1:0] = mieReg;
    end else if (hitMip) begin
      readValue[csrPkg::intWidth-1:0] = mipReg;
    end else if (hitSie) begin
      readValue[csrPkg::intWidth-1:0] = sieReg;
    end else if (hitSip) begin
      readValue[csrPkg::intWidth-1:0] = sipReg;
    end
  end

  // Write, set or clear on the old value; target applies its own mask
  always_comb begin
    case (op)
      csrPkg::opWrite: newValue = wdata;
      csrPkg::opSet:   newValue = readValue | wdata;
      csrPkg::opClear: newValue = readValue & ~wdata;
      default:         newValue = readValue;
    endcase
  end

  ////////////////////
  // Write strobes
  ////////////////////
  assign start   = (state == csrPkg::stIdle) & req;
  assign doWrite = start & accessOk & (op != csrPkg::opRead);

  // One-hot by decode, high for the single idle cycle only
  assign writeMstatus = doWrite & hitMstatus;
  assign writeSstatus = doWrite & hitSstatus;
  assign writeMideleg = doWrite & hitMideleg;
  assign writeMie     = doWrite & hitMie;
  assign writeMip     = doWrite & hitMip;
  assign writeSie     = doWrite & hitSie;
  assign writeSip     = doWrite & hitSip;

  // Handshake FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= csrPkg::stIdle;
      illegal <= 1'b0;
    end else begin
      case (state)
        csrPkg::stIdle: if (req) begin
          state   <= csrPkg::stAck;
          illegal <= ~accessOk;
        end
        default: if (!req) state <= csrPkg::stIdle;   // Wait for req to drop
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) rdata <= accessOk ? readValue : '0;   // Illegal reads return zero
  end

  assign ack = (state == csrPkg::stAck);

endmodule

`default_nettype wire

// File: hw/csrPkg.sv
// Shared CSR numbers, write masks and enums for the interrupt CSR block; covers only M and S interrupt fields
`default_nettype none

package csrPkg;

  ////////////////////
  // CSR numbers
  ////////////////////
  localparam int unsigned csrAddrWidth = 12;    // Standard CSR address width
  localparam int unsigned intWidth     = 12;    // Interrupt field width, up to MEI

  localparam logic [csrAddrWidth-1:0] csrAddrMstatus = 12'h300;
  localparam logic [csrAddrWidth-1:0] csrAddrMideleg = 12'h303;
  localparam logic [csrAddrWidth-1:0] csrAddrMie     = 12'h304;
  localparam logic [csrAddrWidth-1:0] csrAddrMip     = 12'h344;
  localparam logic [csrAddrWidth-1:0] csrAddrSstatus = 12'h100;
  localparam logic [csrAddrWidth-1:0] csrAddrSie     = 12'h104;
  localparam logic [csrAddrWidth-1:0] csrAddrSip     = 12'h144;

  ////////////////////
  // Writable bits
  ////////////////////
  localparam logic [intWidth-1:0] mipWriteMask     = 12'h222;  // SEIP, STIP, SSIP
  localparam logic [intWidth-1:0] sipWriteMask     = 12'h002;  // SSIP only
  localparam logic [intWidth-1:0] mieWriteMask     = 12'hAAA;  // M and S enable fields
  localparam logic [intWidth-1:0] sieWriteMask     = 12'h222;  // S enable fields
  localparam logic [intWidth-1:0] midelegWriteMask = 12'h222;  // Only S interrupts delegate

  ////////////////////
  // Enums
  ////////////////////
  typedef enum logic [1:0] {
    opRead,
    opWrite,
    opSet,
    opClear
  } csrOpT;

  typedef enum logic [1:0] {
    privUser    = 2'd0,
    privSuper   = 2'd1,
    privMachine = 2'd3
  } privT;

  // Cause codes match the bit positions in mip
  typedef enum logic [3:0] {
    causeSsi = 4'd1,
    causeMsi = 4'd3,
    causeSti = 4'd5,
    causeMti = 4'd7,
    causeSei = 4'd9,
    causeMei = 4'd11
  } intCauseT;

  typedef enum logic {
    stIdle,
    stAck
  } accStateT;

endpackage

`default_nettype wire
